// ==== source/mips_pkg.sv ====
package mips_pkg;

    // Primary opcode field, instr[31:26].
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // Function field of SPECIAL, instr[5:0].
    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } alu_op_e;

    typedef enum logic [2:0] {
        S_FETCH,
        S_DECODE,
        S_EXECUTE,
        S_MEM_ACCESS,
        S_WRITEBACK,
        S_HALTED
    } ctrl_state_e;

    // Avalon-MM master outputs.
    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [31:0] writedata;
        logic [3:0]  byteenable;
    } avm_req_t;

    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [31:0] imm;          // Sign extended.
        logic [25:0] target;       // JAL word index.
        alu_op_e     alu_op;
        logic        is_load;
        logic        is_store;
        logic        is_branch_eq;
        logic        is_branch_ne;
        logic        is_jal;
        logic        is_jr;
        logic        writes_rt;
        logic        writes_rd;
        logic        uses_imm;
        logic        illegal;
    } decoded_t;

    localparam logic [31:0] RESET_PC = 32'h4;
    localparam logic [31:0] HALT_PC  = 32'h0;
    localparam logic [4:0]  RA_REG   = 5'd31;
    localparam logic [4:0]  V0_REG   = 5'd2;

endpackage

// ==== source/mips_alu.sv ====
`timescale 1ns/10ps

module mips_alu (
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  mips_pkg::alu_op_e op,
    output logic [31:0]       result,
    output logic              zero
);

    always_comb begin
        case (op)
            mips_pkg::ALU_ADD: result = a + b;  // Wraps, no overflow trap.
            mips_pkg::ALU_SUB: result = a - b;
            mips_pkg::ALU_AND: result = a & b;
            mips_pkg::ALU_OR:  result = a | b;
            mips_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
            default:           result = '0;
        endcase
    end

    // Used by BEQ and BNE after a subtract.
    assign zero = (result == 32'd0);

endmodule

// ==== source/mips_regfile.sv ====
`timescale 1ns/10ps

module mips_regfile (
    input  logic        clk,
    input  logic        arst_n,
    input  logic [4:0]  raddr_a,
    input  logic [4:0]  raddr_b,
    output logic [31:0] rdata_a,
    output logic [31:0] rdata_b,
    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,
    output logic [31:0] v0
);

    logic [31:0] regs [32];

    // Reads are combinational.
    assign rdata_a = regs[raddr_a];
    assign rdata_b = regs[raddr_b];
    assign v0      = regs[mips_pkg::V0_REG];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != 5'd0) begin  // Register 0 stays zero.
            regs[waddr] <= wdata;
        end
    end

endmodule

// ==== source/mips_decoder.sv ====
`timescale 1ns/10ps

module mips_decoder (
    input  logic [31:0]        instr,
    output mips_pkg::decoded_t dec
);

    mips_pkg::opcode_e opcode;
    mips_pkg::funct_e  funct;

    assign opcode = mips_pkg::opcode_e'(instr[31:26]);
    assign funct  = mips_pkg::funct_e'(instr[5:0]);

    always_comb begin
        dec        = '0;
        dec.rs     = instr[25:21];
        dec.rt     = instr[20:16];
        dec.rd     = instr[15:11];
        dec.imm    = {{16{instr[15]}}, instr[15:0]};
        dec.target = instr[25:0];
        dec.alu_op = mips_pkg::ALU_ADD;

        case (opcode)
            mips_pkg::OP_SPECIAL: begin
                dec.writes_rd = 1'b1;
                case (funct)
                    mips_pkg::FN_ADDU: dec.alu_op = mips_pkg::ALU_ADD;
                    mips_pkg::FN_SUBU: dec.alu_op = mips_pkg::ALU_SUB;
                    mips_pkg::FN_AND:  dec.alu_op = mips_pkg::ALU_AND;
                    mips_pkg::FN_OR:   dec.alu_op = mips_pkg::ALU_OR;
                    mips_pkg::FN_SLT:  dec.alu_op = mips_pkg::ALU_SLT;
                    mips_pkg::FN_JR: begin
                        dec.writes_rd = 1'b0;
                        dec.is_jr     = 1'b1;  // Target comes from rs.
                    end
                    default: begin
                        dec.writes_rd = 1'b0;
                        dec.illegal   = 1'b1;
                    end
                endcase
            end
            mips_pkg::OP_ADDIU: begin
                dec.uses_imm  = 1'b1;
                dec.writes_rt = 1'b1;
            end
            mips_pkg::OP_LW: begin
                dec.uses_imm  = 1'b1;
                dec.writes_rt = 1'b1;
                dec.is_load   = 1'b1;
            end
            mips_pkg::OP_SW: begin
                dec.uses_imm = 1'b1;
                dec.is_store = 1'b1;
            end
            mips_pkg::OP_BEQ: begin
                dec.alu_op       = mips_pkg::ALU_SUB;
                dec.is_branch_eq = 1'b1;
            end
            mips_pkg::OP_BNE: begin
                dec.alu_op       = mips_pkg::ALU_SUB;
                dec.is_branch_ne = 1'b1;
            end
            mips_pkg::OP_JAL: dec.is_jal = 1'b1;
            default:          dec.illegal = 1'b1;  // Outside the subset.
        endcase
    end

endmodule

// ==== source/mips_control.sv ====
`timescale 1ns/10ps

module mips_control (
    input  logic               clk,
    input  logic               arst_n,
    output mips_pkg::avm_req_t avm_req,
    input  logic [31:0]        readdata,
    input  logic               waitrequest,
    output logic [31:0]        instr,
    input  mips_pkg::decoded_t dec,
    input  logic [31:0]        rf_rdata_a,
    input  logic [31:0]        rf_rdata_b,
    output logic               rf_we,
    output logic [4:0]         rf_waddr,
    output logic [31:0]        rf_wdata,
    output logic [31:0]        alu_a,
    output logic [31:0]        alu_b,
    output mips_pkg::alu_op_e  alu_op,
    input  logic [31:0]        alu_result,
    input  logic               alu_zero,
    output logic               active
);

    mips_pkg::ctrl_state_e state;
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] next_pc;
    logic [31:0] next_pc_q;
    logic [31:0] opa_q;
    logic [31:0] opb_q;
    logic [31:0] result_q;
    logic [31:0] mdr_q;
    logic        branch_taken;
    logic        xfer_done;
    logic [31:0] req_address;
    logic        req_read;
    logic        req_write;
    logic [31:0] req_writedata;

    assign avm_req = '{address: req_address, read: req_read, write: req_write,
                       writedata: req_writedata, byteenable: 4'hF};  // Word access only.
    assign xfer_done = (req_read || req_write) && !waitrequest;

    assign pc_plus4 = pc + 32'd4;
    assign alu_op   = dec.alu_op;
    assign alu_a    = opa_q;
    assign alu_b    = dec.uses_imm ? dec.imm : opb_q;

    assign branch_taken = (dec.is_branch_eq && alu_zero) || (dec.is_branch_ne && !alu_zero);

    always_comb begin
        if (dec.is_jr)
            next_pc = opa_q;
        else if (dec.is_jal)
            next_pc = {pc_plus4[31:28], dec.target, 2'b00};
        else if (branch_taken)
            next_pc = pc_plus4 + {dec.imm[29:0], 2'b00};  // Word offset from pc+4.
        else
            next_pc = pc_plus4;
    end

    // Writeback port.
    assign rf_we = (state == mips_pkg::S_WRITEBACK) &&
                   (dec.writes_rt || dec.writes_rd || dec.is_jal);
    assign rf_waddr = dec.is_jal ? mips_pkg::RA_REG : (dec.writes_rt ? dec.rt : dec.rd);
    assign rf_wdata = dec.is_load ? mdr_q : (dec.is_jal ? pc_plus4 : result_q);

    // Datapath latches.
    always_ff @(posedge clk) begin
        case (state)
            mips_pkg::S_FETCH:      if (xfer_done) instr <= readdata;
            mips_pkg::S_DECODE: begin
                opa_q <= rf_rdata_a;
                opb_q <= rf_rdata_b;
            end
            mips_pkg::S_EXECUTE: begin
                result_q  <= alu_result;
                next_pc_q <= next_pc;
            end
            mips_pkg::S_MEM_ACCESS: if (xfer_done && req_read) mdr_q <= readdata;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state         <= mips_pkg::S_FETCH;
            pc            <= mips_pkg::RESET_PC;
            active        <= 1'b1;
            req_address   <= '0;
            req_read      <= 1'b0;
            req_write     <= 1'b0;
            req_writedata <= '0;
        end else begin
            case (state)
                mips_pkg::S_FETCH: begin
                    if (!req_read) begin           // First fetch after reset.
                        req_read    <= 1'b1;
                        req_address <= pc;
                    end else if (!waitrequest) begin
                        req_read <= 1'b0;
                        state    <= mips_pkg::S_DECODE;
                    end
                end
                mips_pkg::S_DECODE: begin
                    if (dec.illegal) begin
                        active <= 1'b0;
                        state  <= mips_pkg::S_HALTED;
                    end else begin
                        state <= mips_pkg::S_EXECUTE;
                    end
                end
                mips_pkg::S_EXECUTE: begin
                    if (dec.is_load || dec.is_store) begin
                        req_address   <= alu_result;
                        req_read      <= dec.is_load;
                        req_write     <= dec.is_store;
                        req_writedata <= opb_q;
                        state         <= mips_pkg::S_MEM_ACCESS;
                    end else begin
                        state <= mips_pkg::S_WRITEBACK;
                    end
                end
                mips_pkg::S_MEM_ACCESS: begin
                    if (!waitrequest) begin
                        req_read  <= 1'b0;
                        req_write <= 1'b0;
                        state     <= mips_pkg::S_WRITEBACK;
                    end
                end
                mips_pkg::S_WRITEBACK: begin
                    pc <= next_pc_q;
                    if (next_pc_q == mips_pkg::HALT_PC) begin
                        active <= 1'b0;                // End of program.
                        state  <= mips_pkg::S_HALTED;
                    end else begin
                        req_read    <= 1'b1;           // Next fetch goes out now.
                        req_address <= next_pc_q;
                        state       <= mips_pkg::S_FETCH;
                    end
                end
                default: state <= mips_pkg::S_HALTED;
            endcase
        end
    end

    a_one_request: assert property (@(posedge clk) disable iff (!arst_n)
        !(avm_req.read && avm_req.write));

    // Slave may stall; the master holds everything until the transfer completes.
    a_stable_stall: assert property (@(posedge clk) disable iff (!arst_n)
        (avm_req.read || avm_req.write) && waitrequest |=> $stable(avm_req));

    a_halted_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        state == mips_pkg::S_HALTED |-> !avm_req.read && !avm_req.write && !active);

endmodule

// ==== source/mips_cpu.sv ====
`timescale 1ns/10ps

module mips_cpu (
    input  logic               clk,
    input  logic               arst_n,
    output logic               active,
    output logic [31:0]        register_v0,
    output mips_pkg::avm_req_t avm_req,
    input  logic [31:0]        readdata,
    input  logic               waitrequest
);

    logic [31:0]        instr;
    mips_pkg::decoded_t dec;
    logic [31:0]        rf_rdata_a;
    logic [31:0]        rf_rdata_b;
    logic               rf_we;
    logic [4:0]         rf_waddr;
    logic [31:0]        rf_wdata;
    logic [31:0]        alu_a;
    logic [31:0]        alu_b;
    mips_pkg::alu_op_e  alu_op;
    logic [31:0]        alu_result;
    logic               alu_zero;

    mips_control control_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .avm_req     (avm_req),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .instr       (instr),
        .dec         (dec),
        .rf_rdata_a  (rf_rdata_a),
        .rf_rdata_b  (rf_rdata_b),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .rf_wdata    (rf_wdata),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .alu_op      (alu_op),
        .alu_result  (alu_result),
        .alu_zero    (alu_zero),
        .active      (active)
    );

    mips_decoder decoder_i (
        .instr (instr),
        .dec   (dec)
    );

    // Operand reads follow the rs and rt fields of the held instruction.
    mips_regfile regfile_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .raddr_a (dec.rs),
        .raddr_b (dec.rt),
        .rdata_a (rf_rdata_a),
        .rdata_b (rf_rdata_b),
        .we      (rf_we),
        .waddr   (rf_waddr),
        .wdata   (rf_wdata),
        .v0      (register_v0)
    );

    mips_alu alu_i (
        .a      (alu_a),
        .b      (alu_b),
        .op     (alu_op),
        .result (alu_result),
        .zero   (alu_zero)
    );

endmodule

// ==== testbench/avalon_ram_model.sv ====
`timescale 1ns/10ps

module avalon_ram_model (
    input  logic               clk,
    input  mips_pkg::avm_req_t avm_req,
    output logic [31:0]        readdata,
    output logic               waitrequest,
    input  logic               load,
    input  logic [31:0]        image [256]
);

    logic [31:0] mem [256];
    logic [7:0]  word_idx;
    logic        stall = 1'b0;

    assign word_idx    = avm_req.address[9:2];  // 1 KB space, upper bits ignored.
    assign readdata    = mem[word_idx];
    assign waitrequest = stall;

    // Stall about one cycle in three. Changes only on falling edges.
    always @(negedge clk) begin
        stall <= ($urandom % 3) == 0;
    end

    always @(posedge clk) begin
        if (load) begin
            // Whole program image goes in at once.
            for (int i = 0; i < 256; i++) begin
                mem[i] <= image[i];
            end
        end else if (avm_req.write && !waitrequest) begin
            for (int b = 0; b < 4; b++) begin
                if (avm_req.byteenable[b]) begin
                    mem[word_idx][8*b +: 8] <= avm_req.writedata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== testbench/tb_mips_cpu.sv ====
`timescale 1ns/10ps

module tb_mips_cpu;

    logic               clk = 1'b1;
    logic               arst_n = 1'b1;
    logic               active;
    logic [31:0]        register_v0;
    mips_pkg::avm_req_t avm_req;
    logic [31:0]        readdata;
    logic               waitrequest;
    logic               load = 1'b0;
    logic [31:0]        image [256];

    logic [31:0]        model_regs [32];
    logic [31:0]        model_mem [256];
    logic [31:0]        exp_addr [$];
    logic [31:0]        exp_data [$];
    int                 write_idx = 0;
    int                 pc_w;
    mips_pkg::avm_req_t prev_req = '0;
    logic               prev_stalled = 1'b0;

    mips_cpu dut_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .active      (active),
        .register_v0 (register_v0),
        .avm_req     (avm_req),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    avalon_ram_model mem_i (
        .clk         (clk),
        .avm_req     (avm_req),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .load        (load),
        .image       (image)
    );

    initial begin
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic stop_on_error(string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic expect_equal(string name, logic [31:0] expected, logic [31:0] actual);
        assert (actual === expected)
        else stop_on_error($sformatf("MISMATCH %s expected %08h actual %08h",
                                     name, expected, actual));
    endtask

    function automatic logic [31:0] r_format(logic [5:0] fn, logic [4:0] rs, logic [4:0] rt,
                                             logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_format(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                             logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic append_instr(logic [31:0] word);
        image[pc_w] = word;
        pc_w++;
    endtask

    task automatic append_alu();
        int         pick;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [5:0] fn;
        pick = $urandom % 6;
        rd   = ($urandom % 3 == 0) ? 5'd2 : 5'(1 + $urandom % 8);  // Favor v0.
        rs   = 5'($urandom % 9);
        rt   = 5'($urandom % 9);
        case (pick)
            0:       fn = mips_pkg::FN_ADDU;
            1:       fn = mips_pkg::FN_SUBU;
            2:       fn = mips_pkg::FN_AND;
            3:       fn = mips_pkg::FN_OR;
            default: fn = mips_pkg::FN_SLT;
        endcase
        if (pick == 5)
            append_instr(i_format(mips_pkg::OP_ADDIU, rs, rd, 16'($urandom)));
        else
            append_instr(r_format(fn, rs, rt, rd));
    endtask

    task automatic build_program();
        int          kind;
        int          len;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  tmp;
        logic [15:0] off;
        for (int i = 0; i < 256; i++) begin
            image[i] = 32'hFC00_0000 | (32'(i) << 2);  // Opcode 0x3F is illegal if fetched.
        end
        pc_w = 1;
        for (int r = 1; r <= 8; r++) begin
            append_instr(i_format(mips_pkg::OP_ADDIU, 5'd0, 5'(r), 16'($urandom)));
        end
        repeat (14) begin
            kind = $urandom % 5;
            if (kind <= 1) begin
                append_alu();
            end else if (kind == 2) begin
                len = 1 + $urandom % 3;
                rs  = 5'($urandom % 9);
                rt  = ($urandom % 2 == 0) ? rs : 5'($urandom % 9);  // Equal half the time.
                append_instr(i_format(($urandom % 2 == 0) ? mips_pkg::OP_BEQ : mips_pkg::OP_BNE,
                                      rs, rt, 16'(len)));
                repeat (len) append_alu();
            end else if (kind == 3) begin
                off = 16'(32'h300 + 4 * ($urandom % 64));  // Data region 0x300 to 0x3FC.
                tmp = 5'(1 + $urandom % 8);
                append_instr(i_format(mips_pkg::OP_SW, 5'd0, 5'(1 + $urandom % 8), off));
                append_instr(i_format(mips_pkg::OP_LW, 5'd0, tmp, off));
                append_instr(r_format(mips_pkg::FN_ADDU, 5'd2, tmp, 5'd2));
            end else begin
                append_instr({mips_pkg::OP_JAL, 26'd160});
            end
        end
        append_instr(r_format(mips_pkg::FN_JR, 5'd0, 5'd0, 5'd0));
        // Subroutine at 0x280.
        image[160] = i_format(mips_pkg::OP_ADDIU, 5'd2, 5'd2, 16'($urandom));
        image[161] = r_format(mips_pkg::FN_ADDU, 5'd2, 5'(1 + $urandom % 8), 5'd2);
        image[162] = r_format(mips_pkg::FN_JR, mips_pkg::RA_REG, 5'd0, 5'd0);
    endtask

    function automatic void set_reg(logic [4:0] idx, logic [31:0] val);
        if (idx != 5'd0) model_regs[idx] = val;
    endfunction

    // Instruction-set interpreter without delay slots.
    task automatic run_model();
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] nxt;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] addr;
        logic        stop;
        int          steps;
        for (int i = 0; i < 32; i++) model_regs[i] = '0;
        for (int i = 0; i < 256; i++) model_mem[i] = image[i];
        exp_addr.delete();
        exp_data.delete();
        pc    = mips_pkg::RESET_PC;
        stop  = 1'b0;
        steps = 0;
        while (!stop && steps < 2000) begin
            ins  = model_mem[pc[9:2]];
            a    = model_regs[ins[25:21]];
            b    = model_regs[ins[20:16]];
            imm  = {{16{ins[15]}}, ins[15:0]};
            addr = a + imm;
            nxt  = pc + 32'd4;
            case (ins[31:26])
                mips_pkg::OP_SPECIAL: begin
                    case (ins[5:0])
                        mips_pkg::FN_ADDU: set_reg(ins[15:11], a + b);
                        mips_pkg::FN_SUBU: set_reg(ins[15:11], a - b);
                        mips_pkg::FN_AND:  set_reg(ins[15:11], a & b);
                        mips_pkg::FN_OR:   set_reg(ins[15:11], a | b);
                        mips_pkg::FN_SLT:  set_reg(ins[15:11], {31'd0, $signed(a) < $signed(b)});
                        mips_pkg::FN_JR:   nxt = a;
                        default:           stop = 1'b1;
                    endcase
                end
                mips_pkg::OP_ADDIU: set_reg(ins[20:16], addr);
                mips_pkg::OP_LW:    set_reg(ins[20:16], model_mem[addr[9:2]]);
                mips_pkg::OP_SW: begin
                    model_mem[addr[9:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                mips_pkg::OP_BEQ: if (a == b) nxt = nxt + {imm[29:0], 2'b00};
                mips_pkg::OP_BNE: if (a != b) nxt = nxt + {imm[29:0], 2'b00};
                mips_pkg::OP_JAL: begin
                    set_reg(mips_pkg::RA_REG, nxt);  // Return address is pc+4.
                    nxt = {nxt[31:28], ins[25:0], 2'b00};
                end
                default: stop = 1'b1;
            endcase
            if (nxt == mips_pkg::HALT_PC) stop = 1'b1;
            pc = nxt;
            steps++;
        end
    endtask

    // Bus monitor sampled at the rising edge.
    always @(posedge clk) begin
        if (!arst_n) begin
            assert (!avm_req.read && !avm_req.write)
            else stop_on_error("a bus request was made while reset was asserted");
        end else begin
            assert (!(avm_req.read && avm_req.write))
            else stop_on_error("read and write were asserted in the same cycle");
            if (prev_stalled) begin
                assert (avm_req == prev_req)
                else stop_on_error($sformatf("MISMATCH avm_req expected %h actual %h",
                                             prev_req, avm_req));
            end
            if (avm_req.write && !waitrequest) begin
                assert (write_idx < exp_addr.size())
                else stop_on_error("the CPU made more writes than the model");
                expect_equal("avm_req.address", exp_addr[write_idx], avm_req.address);
                expect_equal("avm_req.writedata", exp_data[write_idx], avm_req.writedata);
                expect_equal("avm_req.byteenable", 32'hF, 32'(avm_req.byteenable));
                write_idx++;
            end
        end
        prev_req     <= avm_req;
        prev_stalled <= arst_n && (avm_req.read || avm_req.write) && waitrequest;
    end

    task automatic wait_for_halt();
        int cycles;
        cycles = 0;
        while (active && cycles < 5000) begin
            @(negedge clk);
            cycles++;
        end
        assert (!active) else stop_on_error("the CPU never halted within 5000 cycles");
    endtask

    initial begin
        void'($urandom(32'h7c12));
        for (int run = 0; run < 20; run++) begin
            build_program();
            run_model();
            @(negedge clk);
            arst_n = 1'b0;
            load   = 1'b1;
            @(negedge clk);
            load = 1'b0;
            repeat (7) @(negedge clk);
            write_idx = 0;
            arst_n    = 1'b1;
            wait_for_halt();
            expect_equal("register_v0", model_regs[2], register_v0);
            expect_equal("write count", 32'(exp_addr.size()), 32'(write_idx));
            // Bus stays quiet once halted.
            repeat (20) begin
                @(negedge clk);
                assert (!avm_req.read && !avm_req.write && !active)
                else stop_on_error("bus activity after the CPU halted");
            end
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
source/mips_pkg.sv
source/mips_alu.sv
source/mips_regfile.sv
source/mips_decoder.sv
source/mips_control.sv
source/mips_cpu.sv
testbench/avalon_ram_model.sv
testbench/tb_mips_cpu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then search the log for the fail message.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_mips_cpu -f flist.f -o sim_tb \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; } || exit 0
